/* flist.f */
source/uart_cfg_pkg.sv
source/uart_stream_pkg.sv
source/uart_rx.sv
source/rx_event_merge.sv
source/dual_uart_rx_top.sv
sim/dual_uart_rx_assertions.sv
sim/tb_dual_uart_rx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the hub testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f --top-module tb_dual_uart_rx -o tb_dual_uart_rx \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_dual_uart_rx > sim.log 2>&1 || echo "Simulator returned an error status"

grep -qx "Test passed" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* sim/dual_uart_rx_assertions.sv */
// Concurrent assertions on the output stream of the hub top level
`timescale 1ns/100ps
`default_nettype none

module dual_uart_rx_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    out_valid,
    input logic                    out_ready,
    input uart_stream_pkg::event_t out_event
);

    import uart_stream_pkg::*;

    // ==================================================================
    // Stream handshake
    // ==================================================================

    // Stalled event stays put until taken
    a_stall_hold : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_event)
    ) else $error("Output event changed or dropped while stalled");

    a_reset_idle : assert property (
        @(posedge clk) rst |=> !out_valid
    ) else $error("Output valid while in reset");

    // ==================================================================
    // Error records
    // ==================================================================

    a_err_reserved : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && out_event.is_error |-> out_event.payload.err.reserved == '0
    ) else $error("Error record with nonzero reserved bits");

endmodule

`default_nettype wire

/* sim/rx_golden.txt */
# R prescale | S ch byte(hex) stop offset hold | G ch width offset
# E ch kind payload(hex), kind D is a data byte and E an error record
R 2
S 0 55 1 10 0
S 0 a3 1 6 0
E 0 D 55
E 0 D a3
R 2
S 0 c4 1 4 0
S 1 3b 1 9 0
S 0 81 1 5 0
S 1 fe 1 3 0
E 0 D c4
E 1 D 3b
E 0 D 81
E 1 D fe
R 2
S 1 5a 0 8 0
S 1 66 1 20 0
E 1 E 80
E 1 D 66
R 2
S 0 11 1 6 600
S 0 22 1 4 0
S 0 33 1 4 0
E 0 D 11
E 0 E 40
E 0 D 33
R 2
G 1 3 12
S 1 9c 1 30 0
E 1 D 9c
R 3
S 0 e7 1 10 0
S 1 18 1 7 0
E 0 D e7
E 1 D 18

/* sim/tb_dual_uart_rx.sv */
// Testbench for the dual UART receive hub, with frames and expected events from a golden file
`timescale 1ns/100ps
`default_nettype none

module tb_dual_uart_rx;

    import uart_cfg_pkg::*;
    import uart_stream_pkg::*;

    // One serial frame, or a short low glitch in its place
    typedef struct packed {
        logic [7:0]        run;
        logic [CH_W-1:0]   ch;
        logic              glitch;
        logic [7:0]        glitch_w;
        logic [DATA_W-1:0] data;
        logic              stop;
        logic [15:0]       offset;              // Idle clocks before the frame
        logic [15:0]       hold;                // Clocks of out_ready held low
    } frame_t;

    typedef struct packed {
        logic [7:0] run;
        event_t     ev;
    } expect_t;

    logic                    clk       = 1'b0;
    logic                    rst       = 1'b1;
    logic [NUM_CH-1:0]       rxd       = '1;
    logic [PRESCALE_W-1:0]   prescale  = PRESCALE_W'(2);
    logic                    out_ready = 1'b0;
    logic                    out_valid;
    event_t                  out_event;
    rx_status_t [NUM_CH-1:0] status;
    logic [NUM_CH-1:0][15:0] hold_load = '0; // One-cycle request to the out_ready driver

    int      run_pres[$];
    frame_t  frames[$];
    expect_t expects[$];
    frame_t  cur_frames[$];
    event_t  cur_exp[$];
    event_t  got_q[$];

    always #10 clk = !clk;

    dual_uart_rx_top i_dual_uart_rx_top (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .prescale  (prescale),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_event (out_event),
        .status    (status)
    );

    bind dual_uart_rx_top dual_uart_rx_assertions i_dual_uart_rx_assertions (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_event (out_event)
    );

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic read_golden();
        int         fd;
        int         rc;
        int         c;
        int         ch;
        int         a;
        int         b;
        int         d;
        int         e;
        logic [7:0] tag;
        logic [7:0] kind;
        frame_t     f;
        expect_t    x;
        fd = $fopen("sim/rx_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the golden file sim/rx_golden.txt");
        end
        rc = $fscanf(fd, " %c", tag);
        while (rc == 1) begin
            if (tag != "#" && tag != "R" && run_pres.size() == 0) begin
                abort_run("Golden file has a record before its first run line");
            end
            f     = '0;
            x     = '0;
            f.run = 8'(run_pres.size() - 1);
            x.run = f.run;
            case (tag)
                "#": begin                      // Skip comment to end of line
                    c = 0;
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "R": begin
                    rc = $fscanf(fd, "%d", a);
                    run_pres.push_back(a);
                end
                "S": begin
                    rc       = $fscanf(fd, "%d %h %d %d %d", ch, a, b, d, e);
                    f.ch     = CH_W'(ch);
                    f.data   = DATA_W'(a);
                    f.stop   = b[0];
                    f.offset = 16'(d);
                    f.hold   = 16'(e);
                    frames.push_back(f);
                end
                "G": begin
                    rc         = $fscanf(fd, "%d %d %d", ch, a, d);
                    f.ch       = CH_W'(ch);
                    f.glitch   = 1'b1;
                    f.glitch_w = 8'(a);
                    f.offset   = 16'(d);
                    frames.push_back(f);
                end
                "E": begin
                    rc                 = $fscanf(fd, "%d %c %h", ch, kind, a);
                    x.ev.ch            = CH_W'(ch);
                    x.ev.is_error      = (kind == "E");
                    x.ev.payload.data  = DATA_W'(a);
                    expects.push_back(x);
                end
                default: abort_run("Golden file has an unknown record type");
            endcase
            rc = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    // Serializes this run's frames for one channel, 8 x prescale clocks per bit
    task automatic send_line(input int ch);
        int     bit_clks;
        int     b;
        frame_t f;
        bit_clks = 8 * int'(prescale);
        foreach (cur_frames[i]) begin
            f = cur_frames[i];
            if (int'(f.ch) == ch) begin
                repeat (int'(f.offset)) @(posedge clk);
                if (f.glitch) begin
                    rxd[ch] <= 1'b0;
                    repeat (int'(f.glitch_w)) @(posedge clk);
                    rxd[ch] <= 1'b1;
                end else begin
                    hold_load[ch] <= f.hold;
                    @(posedge clk);
                    hold_load[ch] <= '0;
                    rxd[ch]       <= 1'b0;      // Start bit
                    repeat (bit_clks) @(posedge clk);
                    // Receiver is inside the frame by the end of the start bit
                    check_value($sformatf("ch %0d busy during frame", ch),
                                32'(status[ch].busy), 32'd1);
                    for (b = 0; b < DATA_W; b++) begin
                        rxd[ch] <= f.data[b];
                        repeat (bit_clks) @(posedge clk);
                    end
                    rxd[ch] <= f.stop;
                    repeat (bit_clks) @(posedge clk);
                    rxd[ch] <= 1'b1;
                end
            end
        end
    endtask

    // ==================================================================
    // Back-pressure and event capture
    // ==================================================================

    initial begin
        logic [NUM_CH-1:0][15:0] hold_cnt;
        logic                    held;
        int                      c;
        hold_cnt = '0;
        void'($urandom(32'h781e));
        forever begin
            @(posedge clk);
            held = 1'b0;
            for (c = 0; c < NUM_CH; c++) begin
                if (hold_load[c] != '0) begin
                    hold_cnt[c] = hold_load[c];
                end else if (hold_cnt[c] != '0) begin
                    hold_cnt[c] = hold_cnt[c] - 16'd1;
                end
                held = held || (hold_cnt[c] != '0);
            end
            out_ready <= !held && (($urandom % 4) != 0);    // Random stalls
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            got_q.push_back(out_event);
        end
    end

    // ==================================================================
    // Runs
    // ==================================================================

    initial begin
        int     r;
        int     c;
        int     k;
        int     base;
        int     target;
        int     cnt;
        event_t exp_ch[$];
        event_t got_ch[$];
        read_golden();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < run_pres.size(); r++) begin
            @(posedge clk);
            prescale <= PRESCALE_W'(run_pres[r]);   // Lines idle between runs
            cur_frames.delete();
            cur_exp.delete();
            foreach (frames[i]) begin
                if (int'(frames[i].run) == r) cur_frames.push_back(frames[i]);
            end
            foreach (expects[i]) begin
                if (int'(expects[i].run) == r) cur_exp.push_back(expects[i].ev);
            end
            @(posedge clk);
            base = got_q.size();
            fork
                send_line(0);
                send_line(1);
            join
            target = base + cur_exp.size();
            cnt    = 0;
            while (got_q.size() < target && cnt < 100000) begin
                @(posedge clk);
                cnt++;
            end
            if (got_q.size() < target) begin
                abort_run($sformatf("Timeout in run %0d while waiting for output events", r));
            end
            // Quiet time so that extra events show up
            cnt = 0;
            while (got_q.size() == target && cnt < 128 * run_pres[r]) begin
                @(posedge clk);
                cnt++;
            end
            for (c = 0; c < NUM_CH; c++) begin
                exp_ch.delete();
                got_ch.delete();
                check_value($sformatf("run %0d ch %0d busy after frames", r, c),
                            32'(status[c].busy), 32'd0);
                foreach (cur_exp[i]) begin
                    if (int'(cur_exp[i].ch) == c) exp_ch.push_back(cur_exp[i]);
                end
                for (k = base; k < got_q.size(); k++) begin
                    if (int'(got_q[k].ch) == c) got_ch.push_back(got_q[k]);
                end
                check_value($sformatf("run %0d ch %0d event count", r, c),
                            32'(got_ch.size()), 32'(exp_ch.size()));
                foreach (exp_ch[i]) begin
                    check_value($sformatf("run %0d ch %0d event %0d", r, c, i),
                                32'(got_ch[i]), 32'(exp_ch[i]));
                end
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/dual_uart_rx_top.sv */
// Top level module joining two UART receivers through the event merge block
`timescale 1ns/100ps
`default_nettype none

module dual_uart_rx_top (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [uart_cfg_pkg::NUM_CH-1:0]                        rxd,
    input  logic [uart_cfg_pkg::PRESCALE_W-1:0]                    prescale,
    input  logic                                                   out_ready,
    output logic                                                   out_valid,
    output uart_stream_pkg::event_t                                out_event,
    output uart_stream_pkg::rx_status_t [uart_cfg_pkg::NUM_CH-1:0] status
);

    import uart_cfg_pkg::*;
    import uart_stream_pkg::*;

    // Receiver to merge streams
    logic     [NUM_CH-1:0] rx_valid;
    logic     [NUM_CH-1:0] rx_ready;
    rx_beat_t [NUM_CH-1:0] rx_beat;
    logic     [NUM_CH-1:0] frame_err;
    logic     [NUM_CH-1:0] overrun_err;

    // ==================================================================
    // Receivers, one per serial line
    // ==================================================================

    for (genvar c = 0; c < NUM_CH; c++) begin : g_rx
        uart_rx i_uart_rx (
            .clk         (clk),
            .rst         (rst),
            .rxd         (rxd[c]),
            .prescale    (prescale),            // Shared bit rate
            .rx_ready    (rx_ready[c]),
            .rx_valid    (rx_valid[c]),
            .rx_beat     (rx_beat[c]),
            .status      (status[c]),
            .frame_err   (frame_err[c]),
            .overrun_err (overrun_err[c])
        );
    end

    // ==================================================================
    // Merge into one tagged stream
    // ==================================================================

    rx_event_merge i_rx_event_merge (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_beat     (rx_beat),
        .frame_err   (frame_err),
        .overrun_err (overrun_err),
        .out_ready   (out_ready),
        .rx_ready    (rx_ready),
        .out_valid   (out_valid),
        .out_event   (out_event)
    );

endmodule

`default_nettype wire

/* source/rx_event_merge.sv */
// Round-robin merge module for receiver streams and error pulses into tagged events
`timescale 1ns/100ps
`default_nettype none

module rx_event_merge (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [uart_cfg_pkg::NUM_CH-1:0]                      rx_valid,
    input  uart_stream_pkg::rx_beat_t [uart_cfg_pkg::NUM_CH-1:0] rx_beat,
    input  logic [uart_cfg_pkg::NUM_CH-1:0]                      frame_err,
    input  logic [uart_cfg_pkg::NUM_CH-1:0]                      overrun_err,
    input  logic                                                 out_ready,
    output logic [uart_cfg_pkg::NUM_CH-1:0]                      rx_ready,
    output logic                                                 out_valid,
    output uart_stream_pkg::event_t                              out_event
);

    import uart_cfg_pkg::*;
    import uart_stream_pkg::*;

    logic [NUM_CH-1:0] pend_frame;              // Sticky error flags
    logic [NUM_CH-1:0] pend_ovr;
    logic [NUM_CH-1:0] pend_err;
    logic [NUM_CH-1:0] has_req;
    logic [CH_W-1:0]   last_grant;
    logic [CH_W-1:0]   grant_ch;
    logic              grant_valid;
    logic              grant_err;
    logic              load;
    err_rec_t          next_err;
    event_t            next_event;

    assign pend_err  = pend_frame | pend_ovr;
    assign has_req   = pend_err | rx_valid;
    assign load      = !out_valid || out_ready; // Output empty or draining
    assign grant_err = grant_valid && pend_err[grant_ch];

    // ==================================================================
    // Arbitration
    // ==================================================================

    // Search starts at the channel after the last grant
    always_comb begin
        logic [CH_W-1:0] idx;
        grant_valid = 1'b0;
        grant_ch    = last_grant;
        for (int i = 1; i <= NUM_CH; i++) begin
            idx = CH_W'((int'(last_grant) + i) % NUM_CH);
            if (!grant_valid && has_req[idx]) begin
                grant_valid = 1'b1;
                grant_ch    = idx;
            end
        end
    end

    // Byte taken only when its channel has no pending error
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            rx_ready[c] = load && grant_valid && !grant_err && (grant_ch == CH_W'(c));
        end
    end

    // Event build
    always_comb begin
        next_err         = '0;
        next_err.frame   = pend_frame[grant_ch];
        next_err.overrun = pend_ovr[grant_ch];

        next_event.ch       = grant_ch;
        next_event.is_error = grant_err;
        if (grant_err) begin
            next_event.payload.err = next_err;
        end else begin
            next_event.payload.data = rx_beat[grant_ch].data;
        end
    end

    // ==================================================================
    // State
    // ==================================================================

    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (load && grant_err && grant_ch == CH_W'(c)) begin
                // Record sent, keep only new pulses
                pend_frame[c] <= frame_err[c];
                pend_ovr[c]   <= overrun_err[c];
            end else begin
                pend_frame[c] <= pend_frame[c] | frame_err[c];
                pend_ovr[c]   <= pend_ovr[c] | overrun_err[c];
            end
        end

        if (load) begin
            out_valid <= grant_valid;
            if (grant_valid) begin
                out_event  <= next_event;
                last_grant <= grant_ch;
            end
        end

        if (rst) begin
            pend_frame <= '0;
            pend_ovr   <= '0;
            out_valid  <= 1'b0;
            last_grant <= CH_W'(NUM_CH - 1);    // Channel 0 served first
        end
    end

endmodule

`default_nettype wire

/* source/uart_cfg_pkg.sv */
// UART hub constants for character format, bit timing, counters and channel tagging
`default_nettype none

package uart_cfg_pkg;

    // ==================================================================
    // Character format
    // ==================================================================

    // Data bits per character, no parity bit
    localparam int DATA_W = 8;

    // Counts start, data and stop bits down to zero
    localparam int BIT_CNT_W = $clog2(DATA_W + 3);

    // ==================================================================
    // Bit timing
    // ==================================================================

    localparam int PRESCALE_W = 16;             // Run-time prescale input

    // Bit period is 8 x prescale clocks
    localparam int BAUD_DIV_W = PRESCALE_W + 3;

    // ==================================================================
    // Channels
    // ==================================================================

    localparam int NUM_CH = 2;                  // Receivers in the hub
    localparam int CH_W   = 1;                  // Channel tag on merged events

endpackage

`default_nettype wire

/* source/uart_rx.sv */
// UART receiver module with 8x prescaled bit timing, stream output and error pulses
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rxd,
    input  logic [uart_cfg_pkg::PRESCALE_W-1:0] prescale,
    input  logic                                rx_ready,
    output logic                                rx_valid,
    output uart_stream_pkg::rx_beat_t           rx_beat,
    output uart_stream_pkg::rx_status_t         status,
    output logic                                frame_err,
    output logic                                overrun_err
);

    import uart_cfg_pkg::*;

    logic                  rxd_reg;             // Input register
    logic                  rxd_prev;            // For falling edge detect
    logic                  busy_reg;
    logic [DATA_W-1:0]     shift_reg;
    logic [BAUD_DIV_W-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [BAUD_DIV_W-1:0] bit_period;
    logic [BAUD_DIV_W-1:0] half_period;
    logic                  start_edge;
    logic                  beat_taken;

    // Reload values for the baud down-counter
    assign bit_period  = {prescale, 3'd0} - BAUD_DIV_W'(1);
    // Middle of start bit, less the edge detect and input register delay
    assign half_period = {1'b0, prescale, 2'd0} - BAUD_DIV_W'(2);

    assign start_edge  = rxd_prev && !rxd_reg;
    assign beat_taken  = rx_valid && rx_ready;
    assign status.busy = busy_reg;

    // ==================================================================
    // Frame sequencing
    // ==================================================================

    always_ff @(posedge clk) begin
        rxd_reg     <= rxd;
        rxd_prev    <= rxd_reg;
        frame_err   <= 1'b0;
        overrun_err <= 1'b0;

        if (beat_taken) begin
            rx_valid <= 1'b0;
        end

        if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - BAUD_DIV_W'(1);
        end else if (bit_cnt > BIT_CNT_W'(DATA_W + 1)) begin
            // Start bit re-check at its middle
            if (!rxd_reg) begin
                bit_cnt  <= bit_cnt - BIT_CNT_W'(1);
                baud_cnt <= bit_period;
            end else begin
                bit_cnt  <= '0;                 // Noise, back to idle
                busy_reg <= 1'b0;
            end
        end else if (bit_cnt > BIT_CNT_W'(1)) begin
            // Data bits, LSB first
            bit_cnt   <= bit_cnt - BIT_CNT_W'(1);
            baud_cnt  <= bit_period;
            shift_reg <= {rxd_reg, shift_reg[DATA_W-1:1]};
        end else if (bit_cnt == BIT_CNT_W'(1)) begin
            // Stop bit
            bit_cnt  <= '0;
            busy_reg <= 1'b0;
            if (rxd_reg) begin
                rx_beat.data <= shift_reg;
                rx_valid     <= 1'b1;
                overrun_err  <= rx_valid && !rx_ready;  // Old byte not taken
            end else begin
                frame_err <= 1'b1;              // Byte dropped
            end
        end else if (start_edge) begin
            baud_cnt <= half_period;
            bit_cnt  <= BIT_CNT_W'(DATA_W + 2);
            busy_reg <= 1'b1;
        end

        if (rst) begin
            rxd_reg     <= 1'b1;                // Line reads idle
            rxd_prev    <= 1'b1;
            busy_reg    <= 1'b0;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            rx_valid    <= 1'b0;
            frame_err   <= 1'b0;
            overrun_err <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/uart_stream_pkg.sv */
// Stream types for receiver beats, error records, payload union, merged events, status
`default_nettype none

package uart_stream_pkg;

    import uart_cfg_pkg::*;

    // ==================================================================
    // Receiver side
    // ==================================================================

    // One beat on the receiver stream
    typedef struct packed {
        logic [DATA_W-1:0] data;                // Received character
    } rx_beat_t;

    // Per-channel status bits
    typedef struct packed {
        logic busy;                             // Frame in progress
    } rx_status_t;

    // ==================================================================
    // Merged event stream
    // ==================================================================

    // Error record, same width as a data byte
    typedef struct packed {
        logic              frame;               // Stop bit read low
        logic              overrun;             // Byte overwritten before taken
        logic [DATA_W-3:0] reserved;            // Always zero
    } err_rec_t;

    // Payload word, decoded by is_error
    typedef union packed {
        logic [DATA_W-1:0] data;
        err_rec_t          err;
    } event_payload_u;

    // Tagged output event
    typedef struct packed {
        logic [CH_W-1:0] ch;                    // Source channel
        logic            is_error;              // Payload holds an error record
        event_payload_u  payload;
    } event_t;

endpackage

`default_nettype wire
